// ==== rtl/pong_consts.svh ====
`ifndef PONG_CONSTS_SVH
`define PONG_CONSTS_SVH

//////////////////////////////////////////////////
// Game pacing
//////////////////////////////////////////////////
`define PONG_TICK_CYCLES 32 // DIV_CLK cycles per game tick
`define PONG_MOVE_TICKS 4   // Paddle ticks per ball step

//////////////////////////////////////////////////
// Ball placement
//////////////////////////////////////////////////
`define PONG_PARK_X 641  // Just past the right edge
`define PONG_PARK_Y 481  // Just past the bottom edge
`define PONG_SERVE_X 315 // Ball origin at serve, centred
`define PONG_SERVE_Y 235
`define PONG_BALL_SIZE 10

//////////////////////////////////////////////////
// Paddles
//////////////////////////////////////////////////
`define PONG_PADDLE_W 10
`define PONG_PADDLE_H 50
`define PONG_LEFT_PADDLE_X 40
`define PONG_RIGHT_PADDLE_X 600
`define PONG_DEADZONE 41   // Subtracted from doubled pot value
`define PONG_PADDLE_MAX 430 // Lowest paddle row, keeps paddle on screen

// Screen limits for the ball origin
`define PONG_GOAL_RIGHT_X 630
`define PONG_FLOOR_Y 470

// Per-step speeds
`define PONG_START_SPEED 2 // First serve of a game
`define PONG_SERVE_SPEED 1 // Serves after a point

`define PONG_WIN_SCORE 9

// Scan counter width, top two bits pick the digit
`define PONG_SCAN_BITS 4

`endif

// ==== rtl/pongPkg.sv ====
`default_nettype none

package pongPkg;

	//////////////////////////////////////////////////
	// Screen coordinates
	//////////////////////////////////////////////////
	typedef logic [10:0] coordX_t; // Up to the park column 641
	typedef logic [9:0] coordY_t;  // Up to the park row 481

	// Ball speed, pixels per step
	typedef logic [6:0] speed_t;

	// One decimal score digit
	typedef logic [3:0] digit_t;

	//////////////////////////////////////////////////
	// Game sequencer states
	//////////////////////////////////////////////////
	typedef enum logic [2:0]
	{
		idle,          // Waiting for start
		setup,         // Clear scores, first serve
		waitServe,     // One tick of pause after a serve
		updatePlayers, // Paddle sampling ticks
		moveBall,      // Ball takes one step
		updateCenter,  // Centre row and right edge refresh
		checkHits,     // Walls, paddles, goals
		score          // Award the point
	} gameState_t;

endpackage

`default_nettype wire

// ==== rtl/paddleMapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module paddleMapper
	import pongPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic playerUpdate, // Sample strobe from sequencer
	input logic [7:0] potValue,
	output coordY_t paddleY
);

	localparam logic [8:0] DeadZone = 9'(`PONG_DEADZONE);
	localparam coordY_t PaddleMax = coordY_t'(`PONG_PADDLE_MAX);

	logic [8:0] scaledPot; // Pot value doubled
	logic [8:0] liftedPot; // After dead zone
	coordY_t clampedRow;

	assign scaledPot = {potValue, 1'b0};

	always_comb
	begin
		// Bottom of the pot travel pins the paddle to the top
		if (scaledPot < DeadZone)
			liftedPot = '0;
		else
			liftedPot = scaledPot - DeadZone;

		if ({1'b0, liftedPot} > PaddleMax)
			clampedRow = PaddleMax; // Keep the whole paddle visible
		else
			clampedRow = {1'b0, liftedPot};
	end

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			paddleY <= '0;
		else if (playerUpdate)
			paddleY <= clampedRow; // One cycle after the strobe
	end

endmodule

`default_nettype wire

// ==== rtl/ballEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module ballEngine
	import pongPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic serveLeft,
	input logic serveRight,
	input logic moveStep,
	input logic centerStep,
	input logic checkStep,
	input logic ballPark,
	input coordY_t leftPaddleY,
	input coordY_t rightPaddleY,
	output coordX_t ballX,
	output coordY_t ballY,
	output logic goalLeft,  // Ball left through the left goal
	output logic goalRight  // Ball left through the right goal
);

	localparam coordX_t ParkX = coordX_t'(`PONG_PARK_X);
	localparam coordY_t ParkY = coordY_t'(`PONG_PARK_Y);
	localparam coordX_t ServeX = coordX_t'(`PONG_SERVE_X);
	localparam coordY_t ServeY = coordY_t'(`PONG_SERVE_Y);
	localparam coordX_t LeftPadX = coordX_t'(`PONG_LEFT_PADDLE_X);
	localparam coordX_t RightPadX = coordX_t'(`PONG_RIGHT_PADDLE_X);
	localparam coordX_t PadW = coordX_t'(`PONG_PADDLE_W);
	localparam coordY_t PadH = coordY_t'(`PONG_PADDLE_H);
	localparam coordX_t SizeX = coordX_t'(`PONG_BALL_SIZE);
	localparam coordY_t HalfY = coordY_t'(`PONG_BALL_SIZE / 2);
	localparam coordX_t GoalRightX = coordX_t'(`PONG_GOAL_RIGHT_X);
	localparam coordY_t FloorY = coordY_t'(`PONG_FLOOR_Y);
	localparam speed_t StartSpeed = speed_t'(`PONG_START_SPEED);
	localparam speed_t ServeSpeed = speed_t'(`PONG_SERVE_SPEED);

	logic dirX;         // 1 moves right
	logic dirY;         // 1 moves down
	speed_t xSpeed;
	speed_t ySpeed;
	coordY_t centerY;   // Registered centre row, for hitbox tests
	coordX_t rightX;    // Registered leading right edge
	logic freshGame;    // Next serve is the first of a game

	coordX_t xStep;
	coordY_t yStep;
	logic leftHit;
	logic rightHit;

	assign xStep = {4'b0000, xSpeed};
	assign yStep = {3'b000, ySpeed};

	//////////////////////////////////////////////////
	// Paddle hitboxes
	//////////////////////////////////////////////////
	// Right edge against the right paddle
	assign rightHit = (rightX >= RightPadX) && (rightX < RightPadX + PadW)
		&& (centerY >= rightPaddleY) && (centerY < rightPaddleY + PadH);
	// Left edge (ball origin) against the left paddle
	assign leftHit = (ballX >= LeftPadX) && (ballX < LeftPadX + PadW)
		&& (centerY >= leftPaddleY) && (centerY < leftPaddleY + PadH);

	//////////////////////////////////////////////////
	// Ball state
	//////////////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			ballX <= ParkX; // Off screen until first serve
			ballY <= ParkY;
			dirX <= 1'b0;
			dirY <= 1'b0;
			xSpeed <= '0;
			ySpeed <= '0;
			centerY <= '0;
			rightX <= '0;
			freshGame <= 1'b1;
		end
		else if (ballPark)
		begin
			ballX <= ParkX;
			ballY <= ParkY;
			freshGame <= 1'b1; // Game over, next serve is fast again
		end
		else if (serveLeft || serveRight)
		begin
			ballX <= ServeX;
			ballY <= ServeY;
			dirX <= serveRight;
			dirY <= 1'b0; // Always starts upward
			xSpeed <= freshGame ? StartSpeed : ServeSpeed;
			ySpeed <= freshGame ? StartSpeed : ServeSpeed;
			centerY <= ServeY + HalfY;
			rightX <= ServeX + SizeX;
			freshGame <= 1'b0;
		end
		else if (moveStep)
		begin
			ballX <= dirX ? ballX + xStep : ballX - xStep;
			ballY <= dirY ? ballY + yStep : ballY - yStep;
		end
		else if (centerStep)
		begin
			centerY <= ballY + HalfY;
			rightX <= ballX + SizeX;
		end
		else if (checkStep)
		begin
			if (ballY < yStep)
				dirY <= 1'b1; // Ceiling
			if (ballY >= FloorY)
				dirY <= 1'b0; // Floor
			// Paddle return speeds the ball up on both axes
			if (rightHit || leftHit)
			begin
				dirX <= leftHit;
				xSpeed <= xSpeed + 1'b1;
				ySpeed <= ySpeed + 1'b1;
			end
		end
	end

	// Goal flags, one cycle after the check
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			goalLeft <= 1'b0;
			goalRight <= 1'b0;
		end
		else
		begin
			goalLeft <= checkStep && (ballX < xStep);
			goalRight <= checkStep && (ballX >= GoalRightX);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gameSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module gameSequencer
	import pongPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic startButton,
	input logic goalLeft,
	input logic goalRight,
	output logic playerUpdate,
	output logic serveLeft,
	output logic serveRight,
	output logic moveStep,
	output logic centerStep,
	output logic checkStep,
	output logic ballPark,
	output logic playing,
	output digit_t leftScore,
	output digit_t rightScore
);

	localparam int TickBits = $clog2(`PONG_TICK_CYCLES);
	localparam int MoveBits = $clog2(`PONG_MOVE_TICKS);
	localparam logic [TickBits-1:0] TickMax = TickBits'(`PONG_TICK_CYCLES - 1);
	localparam logic [MoveBits-1:0] MoveMax = MoveBits'(`PONG_MOVE_TICKS - 1);
	localparam digit_t WinScore = digit_t'(`PONG_WIN_SCORE);

	logic [TickBits-1:0] tickCount;
	logic tick;
	gameState_t state;
	logic [MoveBits-1:0] moveCount; // Paddle ticks in this step
	logic goalPending;
	logic scorerLeft;  // Left player takes the pending point
	digit_t nextScore;
	logic gameWon;

	//////////////////////////////////////////////////
	// Tick divider
	//////////////////////////////////////////////////
	assign tick = (tickCount == TickMax);

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			tickCount <= '0;
		else if (tick)
			tickCount <= '0;
		else
			tickCount <= tickCount + 1'b1;
	end

	// Winner's score after this point
	assign nextScore = (scorerLeft ? leftScore : rightScore) + 1'b1;
	assign gameWon = (nextScore == WinScore);

	// Goal pulses arrive between ticks, hold until the score state
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			goalPending <= 1'b0;
			scorerLeft <= 1'b0;
		end
		else if (goalLeft || goalRight)
		begin
			goalPending <= 1'b1;
			scorerLeft <= goalRight; // Out the right side is a left point
		end
		else if (tick && state == score)
			goalPending <= 1'b0;
	end

	//////////////////////////////////////////////////
	// Game FSM, one state per tick
	//////////////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			moveCount <= '0;
			leftScore <= '0;
			rightScore <= '0;
		end
		else if (tick)
		begin
			case (state)
				idle:
					if (startButton)
						state <= setup;
				setup:
				begin
					leftScore <= '0;
					rightScore <= '0;
					state <= waitServe;
				end
				waitServe:
					state <= updatePlayers;
				updatePlayers:
				begin
					moveCount <= moveCount + 1'b1;
					if (goalPending || moveCount == MoveMax)
						moveCount <= '0;
					if (goalPending)
						state <= score;
					else if (moveCount == MoveMax)
						state <= moveBall;
				end
				moveBall:
					state <= updateCenter;
				updateCenter:
					state <= checkHits;
				checkHits:
					state <= updatePlayers;
				score:
				begin
					if (scorerLeft)
						leftScore <= nextScore;
					else
						rightScore <= nextScore;
					state <= gameWon ? idle : waitServe;
				end
				default:
					state <= idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Command strobes, one DIV_CLK cycle at the tick
	//////////////////////////////////////////////////
	assign playerUpdate = tick && (state == updatePlayers);
	assign moveStep = tick && (state == moveBall);
	assign centerStep = tick && (state == updateCenter);
	assign checkStep = tick && (state == checkHits);
	// Loser of the point receives the serve
	assign serveRight = tick && ((state == setup) || (state == score && scorerLeft && !gameWon));
	assign serveLeft = tick && (state == score) && !scorerLeft && !gameWon;
	assign ballPark = tick && (state == score) && gameWon;
	assign playing = (state != idle);

endmodule

`default_nettype wire

// ==== rtl/scoreScanner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module scoreScanner
	import pongPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input digit_t leftScore,
	input digit_t rightScore,
	output logic [3:0] ssdAnode,   // Active low, bit 0 rightmost
	output logic [6:0] ssdCathode  // Segments a to g, active low
);

	logic [`PONG_SCAN_BITS-1:0] scanCount;
	logic [1:0] scanSel;
	digit_t shownDigit;
	logic [6:0] segments;

	assign scanSel = scanCount[`PONG_SCAN_BITS-1 -: 2]; // Top two bits pick the digit

	// Right score, zero, left score, zero
	always_comb
	begin
		case (scanSel)
			2'd0: shownDigit = rightScore;
			2'd2: shownDigit = leftScore;
			default: shownDigit = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Digit to segment decode
	//////////////////////////////////////////////////
	always_comb
	begin
		case (shownDigit)
			4'd0: segments = 7'b0000001;
			4'd1: segments = 7'b1001111;
			4'd2: segments = 7'b0010010;
			4'd3: segments = 7'b0000110;
			4'd4: segments = 7'b1001100;
			4'd5: segments = 7'b0100100;
			4'd6: segments = 7'b0100000;
			4'd7: segments = 7'b0001111;
			4'd8: segments = 7'b0000000;
			4'd9: segments = 7'b0000100;
			default: segments = 7'b1111111; // Not a score, dark
		endcase
	end

	// Anode and cathodes registered together so they stay paired
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			scanCount <= '0;
			ssdAnode <= 4'b1111; // All digits off
			ssdCathode <= 7'b1111111;
		end
		else
		begin
			scanCount <= scanCount + 1'b1; // Free running
			ssdAnode <= ~(4'b0001 << scanSel);
			ssdCathode <= segments;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pongTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pongTop
	import pongPkg::*;
(
	input logic DIV_CLK,
	input logic reset,
	input logic startButton,
	input logic [7:0] leftPot,   // Pot readings, 8-bit
	input logic [7:0] rightPot,
	output coordX_t ballX,
	output coordY_t ballY,
	output coordY_t leftPaddleY,
	output coordY_t rightPaddleY,
	output logic playing,
	output logic [3:0] ssdAnode,
	output logic [6:0] ssdCathode
);

	logic playerUpdate;
	logic serveLeft;
	logic serveRight;
	logic moveStep;
	logic centerStep;
	logic checkStep;
	logic ballPark;
	logic goalLeft;
	logic goalRight;
	digit_t leftScore;
	digit_t rightScore;

	//////////////////////////////////////////////////
	// Game control
	//////////////////////////////////////////////////
	gameSequencer u_sequencer
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.startButton(startButton),
		.goalLeft(goalLeft),
		.goalRight(goalRight),
		.playerUpdate(playerUpdate),
		.serveLeft(serveLeft),
		.serveRight(serveRight),
		.moveStep(moveStep),
		.centerStep(centerStep),
		.checkStep(checkStep),
		.ballPark(ballPark),
		.playing(playing),
		.leftScore(leftScore),
		.rightScore(rightScore)
	);

	// One mapper per player
	paddleMapper u_leftPaddle
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.playerUpdate(playerUpdate),
		.potValue(leftPot),
		.paddleY(leftPaddleY)
	);

	paddleMapper u_rightPaddle
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.playerUpdate(playerUpdate),
		.potValue(rightPot),
		.paddleY(rightPaddleY)
	);

	ballEngine u_ball
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.serveLeft(serveLeft),
		.serveRight(serveRight),
		.moveStep(moveStep),
		.centerStep(centerStep),
		.checkStep(checkStep),
		.ballPark(ballPark),
		.leftPaddleY(leftPaddleY),
		.rightPaddleY(rightPaddleY),
		.ballX(ballX),
		.ballY(ballY),
		.goalLeft(goalLeft),
		.goalRight(goalRight)
	);

	// Score display
	scoreScanner u_scanner
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.leftScore(leftScore),
		.rightScore(rightScore),
		.ssdAnode(ssdAnode),
		.ssdCathode(ssdCathode)
	);

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic DIV_CLK,
	output logic reset
);

	// 10 ns period
	initial
	begin
		DIV_CLK = 1'b0;
		forever
			#5 DIV_CLK = ~DIV_CLK;
	end

	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge DIV_CLK); // Five cycles in reset
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/pongTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module pongTb
	import pongPkg::*;
();

	localparam int StepCycles = (`PONG_MOVE_TICKS + 3) * `PONG_TICK_CYCLES; // Cycles per ball step
	localparam int PointSteps = 2 * `PONG_GOAL_RIGHT_X / `PONG_SERVE_SPEED; // Two slow crossings
	localparam int MaxPoints = 2 * `PONG_WIN_SCORE - 1;
	localparam int TimeoutCycles = MaxPoints * PointSteps * StepCycles;
	localparam int PaddleWait = 4 * `PONG_TICK_CYCLES + 2; // Covers the three non-paddle ticks
	localparam int FloorLimit = `PONG_FLOOR_Y + `PONG_BALL_SIZE;
	localparam int ScanDwell = 1 << (`PONG_SCAN_BITS - 2); // Cycles per displayed digit

	logic DIV_CLK;
	logic reset;
	logic startButton;
	logic [7:0] leftPot;
	logic [7:0] rightPot;
	coordX_t ballX;
	coordY_t ballY;
	coordY_t leftPaddleY;
	coordY_t rightPaddleY;
	logic playing;
	logic [3:0] ssdAnode;
	logic [6:0] ssdCathode;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	// Scoreboard for the ball and scores
	int prevX = `PONG_PARK_X;
	int prevY = `PONG_PARK_Y;
	int speed = 0;
	int expectSpeed = 0;
	int leftPts = 0;
	int rightPts = 0;
	logic lastDown = 1'b0;
	logic firstStep = 1'b0;
	logic newGame = 1'b0;
	logic serveToRight = 1'b0;
	logic gameOverSeen = 1'b0;

	// Display scan tracking
	logic [3:0] lastAnode = 4'hF;
	int anodeDwell = 0;

	logic [7:0] edgePots [6] = '{8'd0, 8'd20, 8'd21, 8'd235, 8'd236, 8'd255};

	clockGen u_clock
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset)
	);

	pongTop u_dut
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.startButton(startButton),
		.leftPot(leftPot),
		.rightPot(rightPot),
		.ballX(ballX),
		.ballY(ballY),
		.leftPaddleY(leftPaddleY),
		.rightPaddleY(rightPaddleY),
		.playing(playing),
		.ssdAnode(ssdAnode),
		.ssdCathode(ssdCathode)
	);

	//////////////////////////////////////////////////
	// Reference models
	//////////////////////////////////////////////////
	function automatic int expectedRow(input logic [7:0] pot);
		int row;
		row = pot;
		row = 2 * row - `PONG_DEADZONE; // Doubled, minus dead zone
		if (row < 0)
			row = 0;
		if (row > `PONG_PADDLE_MAX)
			row = `PONG_PADDLE_MAX; // Paddle stays on screen
		return row;
	endfunction

	// Active low, a in bit 6
	function automatic logic [6:0] segmentPattern(input int digit);
		case (digit)
			0: return 7'b0000001;
			1: return 7'b1001111;
			2: return 7'b0010010;
			3: return 7'b0000110;
			4: return 7'b1001100;
			5: return 7'b0100100;
			6: return 7'b0100000;
			7: return 7'b0001111;
			8: return 7'b0000000;
			9: return 7'b0000100;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic int scoreAfterGoal(input int points);
		return points + 1;
	endfunction

	function automatic int absDiff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	task automatic checkValue(input string testName, input int expected, input int actual);
		checkCount++;
		if (expected != actual)
		begin
			errorCount++;
			$display("[FAIL] %s: expected %0d, actual %0d", testName, expected, actual);
		end
	endtask

	task automatic reportProblem(input string what);
		errorCount++;
		$display("[ERROR] %s", what);
	endtask

	//////////////////////////////////////////////////
	// Ball and score tracking
	//////////////////////////////////////////////////
	task automatic awardPoint();
		if (prevX >= `PONG_GOAL_RIGHT_X)
		begin
			leftPts = scoreAfterGoal(leftPts); // Out on the right
			serveToRight = 1'b1;
		end
		else if (prevX < speed)
		begin
			rightPts = scoreAfterGoal(rightPts);
			serveToRight = 1'b0;
		end
		else
			reportProblem("ball was reset without passing either goal");
	endtask

	task automatic trackBall();
		int stepX;
		int stepY;
		logic down;
		logic expectDown;
		if (ballX == `PONG_PARK_X && ballY == `PONG_PARK_Y)
		begin
			awardPoint(); // Final point of the game
			gameOverSeen = 1'b1;
			checkValue("game over playing", 0, playing);
			if (leftPts != `PONG_WIN_SCORE && rightPts != `PONG_WIN_SCORE)
				reportProblem("ball parked before a player reached the winning score");
		end
		else if (ballX == `PONG_SERVE_X && ballY == `PONG_SERVE_Y
			&& prevX == `PONG_PARK_X && prevY == `PONG_PARK_Y)
		begin
			leftPts = 0; // Start clears both scores
			rightPts = 0;
			newGame = 1'b1;
			firstStep = 1'b1;
			serveToRight = 1'b1;
			expectSpeed = `PONG_START_SPEED;
			speed = expectSpeed;
		end
		else if (ballX == `PONG_SERVE_X && ballY == `PONG_SERVE_Y
			&& (prevX >= `PONG_GOAL_RIGHT_X || prevX < speed))
		begin
			awardPoint();
			if (leftPts >= `PONG_WIN_SCORE || rightPts >= `PONG_WIN_SCORE)
				reportProblem("ball served again after the winning score");
			firstStep = 1'b1;
			expectSpeed = `PONG_SERVE_SPEED;
			speed = expectSpeed;
		end
		else
		begin
			stepX = absDiff(ballX, prevX);
			stepY = absDiff(ballY, prevY);
			down = (ballY > prevY);
			checkValue("equal step sizes", stepX, stepY);
			if (firstStep)
			begin
				checkValue("serve step size", expectSpeed, stepX);
				checkValue("serve direction", serveToRight, ballX > prevX);
				checkValue("serve starts upward", 0, down);
				if (newGame)
					checkValue("first ballX after start", `PONG_SERVE_X + 2, ballX);
			end
			else
			begin
				if (stepX < speed)
					checkValue("step size not decreasing", speed, stepX);
				// Ceiling when the next step would leave the top
				if (prevY < speed)
					expectDown = 1'b1;
				else if (prevY >= `PONG_FLOOR_Y)
					expectDown = 1'b0;
				else
					expectDown = lastDown;
				checkValue("vertical direction", expectDown, down);
			end
			speed = stepX;
			lastDown = down;
			firstStep = 1'b0;
			newGame = 1'b0;
		end
		prevX = ballX;
		prevY = ballY;
	endtask

	// Cathodes follow the digit picked by the active anode
	task automatic checkDisplay();
		int shown;
		shown = -1;
		case (ssdAnode)
			4'b1110: shown = rightPts;
			4'b1011: shown = leftPts;
			4'b1101, 4'b0111: shown = 0; // Blank positions show zero
			4'b1111: shown = -1;         // All dark, as straight after reset
			default: reportProblem("more than one anode driven at once");
		endcase
		if (shown >= 0)
			checkValue("segments", segmentPattern(shown), ssdCathode);
		// Scan order right, blank, left, blank
		if (ssdAnode != lastAnode)
		begin
			if (lastAnode != 4'hF)
			begin
				checkValue("anode order", {lastAnode[2:0], lastAnode[3]}, ssdAnode);
				checkValue("anode dwell", ScanDwell, anodeDwell);
			end
			lastAnode = ssdAnode;
			anodeDwell = 0;
		end
		anodeDwell++;
		if (anodeDwell == ScanDwell + 1)
			reportProblem("anode scan stopped moving");
	endtask

	//////////////////////////////////////////////////
	// Compare process, sampled mid-cycle
	//////////////////////////////////////////////////
	always @(negedge DIV_CLK)
	begin
		if (!reset)
		begin
			checkDisplay(); // Before the score update of this cycle
			if (ballX != prevX || ballY != prevY)
				trackBall();
			if (!(ballX == `PONG_PARK_X && ballY == `PONG_PARK_Y) && ballY > FloorLimit)
				reportProblem("ballY left the screen");
		end
	end

	// Cycle limit
	always @(posedge DIV_CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Run timed out after %0d cycles", TimeoutCycles);
			$display("Checks run: %0d, errors: %0d", checkCount, errorCount + 1);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		int idx;
		void'($urandom(32'he940_d328));
		startButton = 1'b0;
		leftPot = 8'd0;
		rightPot = 8'd0;
		idx = 0;

		@(negedge DIV_CLK);
		checkValue("reset anodes", 4'hF, ssdAnode); // Reset still high here
		@(negedge reset);
		@(negedge DIV_CLK);
		checkValue("reset playing", 0, playing);
		checkValue("reset ballX", `PONG_PARK_X, ballX);
		checkValue("reset ballY", `PONG_PARK_Y, ballY);
		checkValue("reset left paddle", 0, leftPaddleY);
		checkValue("reset right paddle", 0, rightPaddleY);

		// Hold start until the sequencer leaves idle
		@(posedge DIV_CLK);
		startButton <= 1'b1;
		while (!playing)
			@(posedge DIV_CLK);
		startButton <= 1'b0;

		// Edge pot values first, random after
		while (playing)
		begin
			@(posedge DIV_CLK);
			if (idx < 6)
			begin
				leftPot <= edgePots[idx];
				rightPot <= edgePots[5 - idx];
			end
			else
			begin
				leftPot <= 8'($urandom);
				rightPot <= 8'($urandom);
			end
			idx++;
			repeat (PaddleWait) @(posedge DIV_CLK);
			@(negedge DIV_CLK);
			if (playing)
			begin
				checkValue("left paddle row", expectedRow(leftPot), leftPaddleY);
				checkValue("right paddle row", expectedRow(rightPot), rightPaddleY);
			end
		end

		repeat (2) @(negedge DIV_CLK); // Let the tracker see the park
		if (!gameOverSeen)
			reportProblem("game ended without the ball parking");
		checkValue("winner score", `PONG_WIN_SCORE, (leftPts > rightPts) ? leftPts : rightPts);
		checkValue("parked ballX", `PONG_PARK_X, ballX);
		checkValue("parked ballY", `PONG_PARK_Y, ballY);

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pong.f ====
+incdir+rtl
rtl/pongPkg.sv
rtl/paddleMapper.sv
rtl/ballEngine.sv
rtl/gameSequencer.sv
rtl/scoreScanner.sv
rtl/pongTop.sv
dv/clockGen.sv
dv/pongTb.sv

// ==== Bender.yml ====
package:
  name: pong

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pongPkg.sv
      - rtl/paddleMapper.sv
      - rtl/ballEngine.sv
      - rtl/gameSequencer.sv
      - rtl/scoreScanner.sv
      - rtl/pongTop.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - dv/clockGen.sv
      - dv/pongTb.sv
